// ==== rtl/cgra_pkg.sv ====
package cgra_pkg;

    localparam int data_w   = 32;
    localparam int inst_w   = 28;
    localparam int pe_count = 4;

    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_mul    = 4'd2,
        op_and    = 4'd3,
        op_or     = 4'd4,
        op_xor    = 4'd5,
        op_shl    = 4'd6,
        op_shr    = 4'd7,
        op_pass_a = 4'd8,
        op_min    = 4'd9     // Unsigned minimum.
    } fu_op_t;

    typedef enum logic [2:0] {
        src_in0  = 3'd0,
        src_in1  = 3'd1,
        src_r0   = 3'd2,
        src_r1   = 3'd3,
        src_r2   = 3'd4,
        src_r3   = 3'd5,
        src_res  = 3'd6,
        src_zero = 3'd7
    } xbar_src_t;

    // One configuration word, 28 bits, most significant field first.
    typedef struct packed {
        fu_op_t     op;
        xbar_src_t  sel_a;
        xbar_src_t  sel_b;
        xbar_src_t  sel_n;
        xbar_src_t  sel_s;
        xbar_src_t  sel_w;
        xbar_src_t  sel_e;
        logic       swap_ns;   // Set puts north on in0 and west on in1.
        logic       swap_we;   // Set puts south on in2.
        logic [3:0] rf_load;   // Bit i loads register i.
    } pe_inst_t;

endpackage

// ==== rtl/pe_regfile.sv ====
module pe_regfile import cgra_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [3:0]        rf_load,
    input  logic [data_w-1:0] in0,
    input  logic [data_w-1:0] in1,
    input  logic [data_w-1:0] in2,
    input  logic [data_w-1:0] res,
    output logic [data_w-1:0] r0,
    output logic [data_w-1:0] r1,
    output logic [data_w-1:0] r2,
    output logic [data_w-1:0] r3
);

    logic [data_w-1:0] rf_d [4];
    logic [data_w-1:0] rf_q [4];

    assign rf_d[0] = in0;
    assign rf_d[1] = in1;
    assign rf_d[2] = in2;
    assign rf_d[3] = res;   // R3 feeds back the result so the element can accumulate.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (rf_load[i]) begin
                    rf_q[i] <= rf_d[i];
                end
            end
        end
    end

    assign r0 = rf_q[0];
    assign r1 = rf_q[1];
    assign r2 = rf_q[2];
    assign r3 = rf_q[3];

endmodule

// ==== rtl/pe_crossbar.sv ====
module pe_crossbar import cgra_pkg::*; (
    input  xbar_src_t         sel_a,
    input  xbar_src_t         sel_b,
    input  xbar_src_t         sel_n,
    input  xbar_src_t         sel_s,
    input  xbar_src_t         sel_w,
    input  xbar_src_t         sel_e,
    input  logic [data_w-1:0] in0,
    input  logic [data_w-1:0] in1,
    input  logic [data_w-1:0] r0,
    input  logic [data_w-1:0] r1,
    input  logic [data_w-1:0] r2,
    input  logic [data_w-1:0] r3,
    input  logic [data_w-1:0] res,
    output logic [data_w-1:0] op_a,
    output logic [data_w-1:0] op_b,
    output logic [data_w-1:0] out_n,
    output logic [data_w-1:0] out_s,
    output logic [data_w-1:0] out_w,
    output logic [data_w-1:0] out_e
);

    // Source table indexed directly by the xbar_src_t code.
    logic [data_w-1:0] src [8];

    assign src[src_in0]  = in0;
    assign src[src_in1]  = in1;
    assign src[src_r0]   = r0;
    assign src[src_r1]   = r1;
    assign src[src_r2]   = r2;
    assign src[src_r3]   = r3;
    assign src[src_res]  = res;
    assign src[src_zero] = '0;

    // Six independent selectors; any output may pick any source.
    assign op_a  = src[sel_a];
    assign op_b  = src[sel_b];
    assign out_n = src[sel_n];
    assign out_s = src[sel_s];
    assign out_w = src[sel_w];
    assign out_e = src[sel_e];

endmodule

// ==== rtl/pe_alu.sv ====
module pe_alu import cgra_pkg::*; (
    input  fu_op_t            op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Shift distance uses the low five bits only.

    always_comb begin
        case (op)
            op_add:    y = a + b;
            op_sub:    y = a - b;
            op_mul:    y = a * b;   // Low 32 bits of the product.
            op_and:    y = a & b;
            op_or:     y = a | b;
            op_xor:    y = a ^ b;
            op_shl:    y = a << shamt;
            op_shr:    y = a >> shamt;
            op_pass_a: y = a;
            op_min:    y = (a < b) ? a : b;
            default:   y = '0;      // Unassigned opcodes produce zero.
        endcase
    end

endmodule

// ==== rtl/pe.sv ====
module pe import cgra_pkg::*; #(
    parameter int buffer_depth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic              run,
    input  pe_inst_t          inst,
    input  logic [data_w-1:0] in_n,
    input  logic [data_w-1:0] in_w,
    input  logic [data_w-1:0] in_s,
    input  logic [data_w-1:0] in_e,
    output logic [data_w-1:0] out_n,
    output logic [data_w-1:0] out_w,
    output logic [data_w-1:0] out_s,
    output logic [data_w-1:0] out_e
);

    localparam int idx_w = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;

    logic [inst_w-1:0] cfg_buf [buffer_depth];
    logic [idx_w-1:0]  wr_idx;
    logic [idx_w-1:0]  run_idx;
    pe_inst_t          act;
    logic [data_w-1:0] in0;
    logic [data_w-1:0] in1;
    logic [data_w-1:0] in2;
    logic [data_w-1:0] r0;
    logic [data_w-1:0] r1;
    logic [data_w-1:0] r2;
    logic [data_w-1:0] r3;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] fu_y;
    logic [data_w-1:0] res;

    function automatic logic [idx_w-1:0] next_idx(input logic [idx_w-1:0] idx);
        if (idx == idx_w'(buffer_depth - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_idx  <= '0;
            run_idx <= '0;
            act     <= '0;
        end else if (load) begin   // Loading wins over run in the same cycle.
            wr_idx <= next_idx(wr_idx);
        end else if (run) begin
            run_idx <= next_idx(run_idx);
            act     <= pe_inst_t'(cfg_buf[run_idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cfg_buf[wr_idx] <= inst;
        end
    end

    assign in0 = act.swap_ns ? in_n : in_w;
    assign in1 = act.swap_ns ? in_w : in_n;
    assign in2 = act.swap_we ? in_s : in_e;

    pe_regfile u_rf (
        .clk(clk), .rst(rst), .rf_load(act.rf_load),
        .in0(in0), .in1(in1), .in2(in2), .res(fu_y),
        .r0(r0), .r1(r1), .r2(r2), .r3(r3)
    );

    pe_crossbar u_xbar (
        .sel_a(act.sel_a), .sel_b(act.sel_b), .sel_n(act.sel_n),
        .sel_s(act.sel_s), .sel_w(act.sel_w), .sel_e(act.sel_e),
        .in0(in0), .in1(in1), .r0(r0), .r1(r1), .r2(r2), .r3(r3), .res(res),
        .op_a(op_a), .op_b(op_b),
        .out_n(out_n), .out_s(out_s), .out_w(out_w), .out_e(out_e)
    );

    pe_alu u_alu (.op(act.op), .a(op_a), .b(op_b), .y(fu_y));

    always_ff @(posedge clk) begin
        if (rst) begin
            res <= '0;
        end else begin
            res <= fu_y;
        end
    end

endmodule

// ==== rtl/cgra_array.sv ====
module cgra_array import cgra_pkg::*; #(
    parameter int buffer_depth = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_load,
    input  logic [1:0]        cfg_pe,
    input  pe_inst_t          cfg_inst,
    input  logic              run,
    input  logic [data_w-1:0] west_in   [2],
    input  logic [data_w-1:0] north_in  [2],
    output logic [data_w-1:0] east_out  [2],
    output logic [data_w-1:0] south_out [2]
);

    localparam int dim = 2;

    logic [pe_count-1:0] pe_load;
    logic [data_w-1:0]   in_n  [dim][dim];
    logic [data_w-1:0]   in_w  [dim][dim];
    logic [data_w-1:0]   in_s  [dim][dim];
    logic [data_w-1:0]   in_e  [dim][dim];
    logic [data_w-1:0]   out_n [dim][dim];
    logic [data_w-1:0]   out_w [dim][dim];
    logic [data_w-1:0]   out_s [dim][dim];
    logic [data_w-1:0]   out_e [dim][dim];

    // Element index is row * 2 + column, so cfg_pe reads as {row, column}.
    for (genvar i = 0; i < pe_count; i++) begin : g_dec
        assign pe_load[i] = cfg_load && (cfg_pe == 2'(i));
    end

    for (genvar r = 0; r < dim; r++) begin : g_row
        for (genvar c = 0; c < dim; c++) begin : g_col
            if (c == 0) begin : g_w_edge
                assign in_w[r][c] = west_in[r];
            end else begin : g_w_link
                assign in_w[r][c] = out_e[r][c-1];
            end

            if (c == dim - 1) begin : g_e_edge
                assign in_e[r][c] = '0;   // Nothing drives the east boundary.
            end else begin : g_e_link
                assign in_e[r][c] = out_w[r][c+1];
            end

            if (r == 0) begin : g_n_edge
                assign in_n[r][c] = north_in[c];
            end else begin : g_n_link
                assign in_n[r][c] = out_s[r-1][c];
            end

            if (r == dim - 1) begin : g_s_edge
                assign in_s[r][c] = '0;
            end else begin : g_s_link
                assign in_s[r][c] = out_n[r+1][c];
            end

            pe #(.buffer_depth(buffer_depth)) u_pe (
                .clk(clk), .rst(rst), .load(pe_load[r*dim+c]), .run(run),
                .inst(cfg_inst),
                .in_n(in_n[r][c]), .in_w(in_w[r][c]),
                .in_s(in_s[r][c]), .in_e(in_e[r][c]),
                .out_n(out_n[r][c]), .out_w(out_w[r][c]),
                .out_s(out_s[r][c]), .out_e(out_e[r][c])
            );
        end
    end

    for (genvar k = 0; k < dim; k++) begin : g_edge_out
        assign east_out[k]  = out_e[k][dim-1];
        assign south_out[k] = out_s[dim-1][k];
    end

endmodule

// ==== testbench/tb_cgra.sv ====
module tb_cgra import cgra_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth      = 8;
    localparam int n_rows     = 30;
    localparam int step_limit = 2 * depth;   // Run cycles allowed to reach any step.

    logic              clk;
    logic              rst;
    logic              cfg_load;
    logic [1:0]        cfg_pe;
    pe_inst_t          cfg_inst;
    logic              run;
    logic [data_w-1:0] west_in   [2];
    logic [data_w-1:0] north_in  [2];
    logic [data_w-1:0] east_out  [2];
    logic [data_w-1:0] south_out [2];

    logic [3:0]        tab_code  [n_rows];   // Opcode held in slot 0 of element (0,0).
    int                tab_step  [n_rows];
    logic [data_w-1:0] tab_west  [n_rows][2];
    logic [data_w-1:0] tab_north [n_rows][2];
    logic [data_w-1:0] tab_east  [n_rows][2];
    logic [data_w-1:0] tab_south [n_rows][2];

    integer            seed;
    int                next_slot;   // Run index, shared by all elements.
    logic [3:0]        loaded_code;
    bit                reloaded;
    logic [data_w-1:0] acc_x;
    logic [data_w-1:0] acc_first;

    cgra_array #(.buffer_depth(depth)) u_dut (
        .clk(clk), .rst(rst), .cfg_load(cfg_load), .cfg_pe(cfg_pe), .cfg_inst(cfg_inst),
        .run(run), .west_in(west_in), .north_in(north_in),
        .east_out(east_out), .south_out(south_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_data(logic [data_w-1:0] got, logic [data_w-1:0] exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_step(fu_op_t got, fu_op_t exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // Slot 0 of element (0,0) carries the opcode under test, the others use their slot number.
    function automatic logic [3:0] slot_op(logic [3:0] code, int slot);
        if (slot == 0) begin
            return code;
        end
        return slot[3:0];
    endfunction

    function automatic logic [data_w-1:0] op_result(logic [3:0] code, logic [data_w-1:0] a,
                                                     logic [data_w-1:0] b);
        case (code)
            4'd0: return a + b;
            4'd1: return a + ~b + 32'd1;
            4'd2: return a * b;
            4'd3: return a & b;
            4'd4: return a | b;
            4'd5: return a ^ b;
            4'd6: return a * (32'd1 << b[4:0]);
            4'd7: return a / (32'd1 << b[4:0]);
            4'd8: return a;
            4'd9: return (b < a) ? b : a;
            default: return '0;
        endcase
    endfunction

    function automatic pe_inst_t make_inst(int pe_idx, int slot, logic [3:0] code);
        pe_inst_t w;
        w       = '0;
        w.sel_a = src_in0;
        w.sel_b = src_in1;
        w.sel_n = src_zero;
        w.sel_w = src_zero;
        w.sel_s = src_zero;
        w.sel_e = src_in0;
        case (pe_idx)
            0: begin
                w.op    = fu_op_t'(slot_op(code, slot));
                w.sel_s = src_in1;   // north_in[0] goes down to (1,0).
                w.sel_e = src_res;
            end
            1: begin
                w.swap_ns = 1'b1;
                w.sel_s   = src_in0;   // north_in[1] goes down to (1,1).
                w.sel_e   = src_in1;   // The result from (0,0).
            end
            2: begin
                w.swap_ns = 1'b1;
                w.swap_we = 1'b1;
            end
            default: w.sel_s = src_in1;
        endcase
        return w;
    endfunction

    function automatic pe_inst_t acc_inst();
        pe_inst_t w;
        w         = make_inst(3, 0, 4'd0);
        w.sel_a   = src_r3;
        w.sel_b   = src_in0;
        w.sel_s   = src_r3;
        w.rf_load = 4'b1000;
        return w;
    endfunction

    task automatic build_table();
        int i;
        i = 0;
        for (int g = 0; g < 11; g++) begin
            for (int k = 0; k < 2; k++) begin
                tab_code[i] = (g == 10) ? 4'hf : g[3:0];
                tab_step[i] = 0;
                i++;
            end
        end
        for (int s = 1; s <= depth; s++) begin   // Walk every slot and wrap to slot 0.
            tab_code[i] = 4'hf;
            tab_step[i] = s % depth;
            i++;
        end
        for (int r = 0; r < n_rows; r++) begin
            for (int k = 0; k < 2; k++) begin
                tab_west[r][k]  = $random(seed);
                tab_north[r][k] = $random(seed);
            end
            tab_east[r][0]  = op_result(slot_op(tab_code[r], tab_step[r]),
                                        tab_west[r][0], tab_north[r][0]);
            tab_east[r][1]  = tab_north[r][0];
            tab_south[r][0] = '0;
            tab_south[r][1] = tab_north[r][1];
        end
    endtask

    task automatic load_program(int pe_idx, logic [3:0] code, bit acc);
        for (int s = 0; s < depth; s++) begin
            @(posedge clk);
            cfg_load <= 1'b1;
            cfg_pe   <= 2'(pe_idx);
            cfg_inst <= acc ? acc_inst() : make_inst(pe_idx, s, code);
        end
        @(posedge clk);
        cfg_load <= 1'b0;
    endtask

    // Holds run high one cycle per slot until the requested slot is active.
    task automatic goto_step(int step, bit force_pulse);
        int pulses;
        pulses = 0;
        while (force_pulse || next_slot != (step + 1) % depth) begin
            if (pulses == step_limit) begin
                abort_run("timed out waiting for the run index to reach the requested step");
            end
            @(posedge clk);
            run <= 1'b1;
            next_slot   = (next_slot + 1) % depth;
            force_pulse = 1'b0;
            pulses++;
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin
        seed        = 32'hbcdf4058;
        rst         = 1'b1;
        cfg_load    = 1'b0;
        cfg_pe      = 2'd0;
        cfg_inst    = '0;
        run         = 1'b0;
        west_in[0]  = '0;
        west_in[1]  = '0;
        north_in[0] = '0;
        north_in[1] = '0;
        next_slot   = 0;
        build_table();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        for (int k = 0; k < 2; k++) begin
            check_data(east_out[k], '0, $sformatf("east_out[%0d] after reset", k));
            check_data(south_out[k], '0, $sformatf("south_out[%0d] after reset", k));
        end

        for (int p = 0; p < pe_count; p++) begin
            load_program(p, tab_code[0], 1'b0);
        end
        loaded_code = tab_code[0];

        for (int i = 0; i < n_rows; i++) begin
            reloaded = 1'b0;
            if (tab_code[i] !== loaded_code) begin   // Only (0,0) is loaded again.
                load_program(0, tab_code[i], 1'b0);
                loaded_code = tab_code[i];
                reloaded    = 1'b1;
            end
            @(posedge clk);
            west_in[0]  <= tab_west[i][0];
            west_in[1]  <= tab_west[i][1];
            north_in[0] <= tab_north[i][0];
            north_in[1] <= tab_north[i][1];
            goto_step(tab_step[i], reloaded);
            repeat (5) @(posedge clk);
            @(negedge clk);
            check_step(u_dut.g_row[0].g_col[0].u_pe.act.op,
                       fu_op_t'(slot_op(tab_code[i], tab_step[i])),
                       $sformatf("opcode of element (0,0) in row %0d", i));
            for (int k = 0; k < 2; k++) begin
                check_data(east_out[k], tab_east[i][k], $sformatf("east_out[%0d] row %0d", k, i));
                check_data(south_out[k], tab_south[i][k],
                           $sformatf("south_out[%0d] row %0d", k, i));
            end
        end

        // R3 adds the input to itself at every edge.
        acc_x = tab_north[n_rows-1][0];
        load_program(3, 4'd0, 1'b1);
        goto_step(3, 1'b1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        acc_first = south_out[1];
        check_step(u_dut.g_row[0].g_col[0].u_pe.act.op, op_and, "opcode of element (0,0)");
        check_data(east_out[0], op_result(4'd3, tab_west[n_rows-1][0], acc_x),
                   "east_out[0] after loading element (1,1)");
        check_data(east_out[1], acc_x, "east_out[1] after loading element (1,1)");
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_data(south_out[1] - acc_first, acc_x * 32'd6, "accumulated growth over 6 cycles");

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/cgra_pkg.sv
rtl/pe_regfile.sv
rtl/pe_crossbar.sv
rtl/pe_alu.sv
rtl/pe.sv
rtl/cgra_array.sv
testbench/tb_cgra.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_cgra
FILELIST  := sim.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
